// File: Bender.yml
package:
  name: weight_buffer

sources:
  - source/weight_geom_pkg.sv
  - source/weight_bank_pkg.sv
  - source/weight_load_ctrl.sv
  - source/weight_bank_sel.sv
  - source/weight_bank.sv
  - source/weight_buffer.sv
  - target: test
    files:
      - bench/weight_buffer_checker.sv
      - bench/tb_weight_buffer.sv

// File: bench/tb_weight_buffer.sv
// testbench top for the weight buffer, runs the stimulus table against a modeled FIFO
`default_nettype none

module tb_weight_buffer;

    localparam int NUM_TESTS    = 4;
    localparam int DONE_TIMEOUT = 2000;  // cycles to wait for weight_load_done

    typedef struct packed {
        logic [95:0] name;
        logic [15:0] base;      // word n = base + n*step
        logic [15:0] step;
        logic [7:0]  gap_pct;   // chance of an empty cycle
        logic [7:0]  extra;     // words queued beyond one load
        logic        tile_rst;  // pulse conv_tile_reset first
    } test_row_t;

    logic clk;
    logic rst;
    logic weight_load_start;
    logic conv_tile_reset;
    logic weight_load_done;
    logic weight_fifo_empty;
    logic weight_fifo_pop;
    logic [weight_bank_pkg::DATA_W-1:0] weight_fifo_data;
    logic [weight_bank_pkg::BANK_COUNT-1:0][weight_bank_pkg::BANK_ADDR_W-1:0] rd_addr;
    logic [weight_bank_pkg::BANK_COUNT-1:0][weight_bank_pkg::DATA_W-1:0]      rd_data;

    test_row_t tests [NUM_TESTS];
    logic [weight_bank_pkg::DATA_W-1:0] fifo_q [$];
    logic [95:0]                        test_name;
    logic [weight_bank_pkg::DATA_W-1:0] test_base;
    logic [weight_bank_pkg::DATA_W-1:0] test_step;
    int   gap_pct;
    int   words_left_expected;
    int   words_left;
    logic sweep_active;
    logic load_timeout;
    logic test_end;
    int   tests_run;
    int   tests_failed;
    int   error_total;

    weight_buffer weight_buffer_inst (
        .clk               (clk),
        .rst               (rst),
        .weight_load_start (weight_load_start),
        .conv_tile_reset   (conv_tile_reset),
        .weight_load_done  (weight_load_done),
        .weight_fifo_empty (weight_fifo_empty),
        .weight_fifo_data  (weight_fifo_data),
        .weight_fifo_pop   (weight_fifo_pop),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data)
    );

    weight_buffer_checker weight_buffer_checker_inst (
        .clk                 (clk),
        .rst                 (rst),
        .weight_load_start   (weight_load_start),
        .conv_tile_reset     (conv_tile_reset),
        .weight_fifo_empty   (weight_fifo_empty),
        .weight_fifo_pop     (weight_fifo_pop),
        .weight_load_done    (weight_load_done),
        .rd_addr             (rd_addr),
        .rd_data             (rd_data),
        .test_name           (test_name),
        .test_base           (test_base),
        .test_step           (test_step),
        .words_left_expected (words_left_expected),
        .words_left          (words_left),
        .sweep_active        (sweep_active),
        .load_timeout        (load_timeout),
        .test_end            (test_end),
        .tests_run           (tests_run),
        .tests_failed        (tests_failed),
        .error_total         (error_total)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // FIFO consumes its head word on each edge with pop high
    always @(posedge clk) begin
        if (weight_fifo_pop && fifo_q.size() > 0) begin
            fifo_q.delete(0);
        end
    end

    // columns: name, base, step, gap percent, extra words, tile reset before the load
    task automatic load_table();
        tests[0] = '{"gap_free    ", 16'h1000, 16'h0001, 8'd0,  8'd0,  1'b0};
        tests[1] = '{"gap_40pct   ", 16'ha5a5, 16'h0101, 8'd40, 8'd0,  1'b1};
        tests[2] = '{"extra_words ", 16'h8000, 16'h1357, 8'd10, 8'd10, 1'b1};
        tests[3] = '{"reload      ", 16'hffff, 16'hfff1, 8'd25, 8'd3,  1'b1};
    endtask

    // advance to the next falling edge and present the FIFO head
    task automatic next_cycle();
        @(negedge clk);
        if (fifo_q.size() == 0) begin
            weight_fifo_empty = 1'b1;
            weight_fifo_data  = '0;
        end else begin
            weight_fifo_empty = (($urandom % 100) < gap_pct);  // random gap
            weight_fifo_data  = fifo_q[0];
        end
    endtask

    task automatic run_test(input test_row_t row);
        int cycles;
        test_name           = row.name;
        test_base           = row.base;
        test_step           = row.step;
        gap_pct             = row.gap_pct;
        words_left_expected = row.extra;
        load_timeout        = 1'b0;
        if (row.tile_rst) begin
            conv_tile_reset = 1'b1;
            next_cycle();
            conv_tile_reset = 1'b0;
        end
        for (int n = 0; n < weight_geom_pkg::LOAD_WORDS + row.extra; n++) begin
            fifo_q.push_back(weight_bank_pkg::DATA_W'(row.base + n * row.step));
        end
        repeat (4) next_cycle();  // words waiting, no start yet
        weight_load_start = 1'b1;
        next_cycle();
        weight_load_start = 1'b0;
        cycles = 0;
        while (!weight_load_done && cycles < DONE_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        load_timeout = !weight_load_done;
        if (!load_timeout) begin
            sweep_active = 1'b1;
            for (int a = 0; a < weight_bank_pkg::BANK_DEPTH; a++) begin
                for (int b = 0; b < weight_bank_pkg::BANK_COUNT; b++) begin
                    rd_addr[b] = a[weight_bank_pkg::BANK_ADDR_W-1:0];
                end
                next_cycle();
            end
            sweep_active = 1'b0;
            next_cycle();  // last read compared here
        end
        words_left = fifo_q.size();
        test_end   = 1'b1;
        next_cycle();
        test_end   = 1'b0;
        fifo_q.delete();
    endtask

    initial begin
        void'($urandom(79631));
        rst                 = 1'b1;
        weight_load_start   = 1'b0;
        conv_tile_reset     = 1'b0;
        weight_fifo_empty   = 1'b1;
        weight_fifo_data    = '0;
        rd_addr             = '0;
        gap_pct             = 0;
        test_name           = '0;
        test_base           = '0;
        test_step           = '0;
        words_left_expected = 0;
        words_left          = 0;
        sweep_active        = 1'b0;
        load_timeout        = 1'b0;
        test_end            = 1'b0;
        load_table();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(tests[t]);
        end
        next_cycle();
        next_cycle();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_total);
        if (tests_failed == 0 && error_total == 0 && tests_run == NUM_TESTS) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/weight_buffer_checker.sv
// testbench checker, watches the weight buffer ports, predicts every bank word and reports per test
`default_nettype none

module weight_buffer_checker (
    input  logic clk,
    input  logic rst,
    input  logic weight_load_start,
    input  logic conv_tile_reset,
    input  logic weight_fifo_empty,
    input  logic weight_fifo_pop,
    input  logic weight_load_done,
    input  logic [weight_bank_pkg::BANK_COUNT-1:0][weight_bank_pkg::BANK_ADDR_W-1:0] rd_addr,
    input  logic [weight_bank_pkg::BANK_COUNT-1:0][weight_bank_pkg::DATA_W-1:0]      rd_data,
    input  logic [95:0]                        test_name,
    input  logic [weight_bank_pkg::DATA_W-1:0] test_base,
    input  logic [weight_bank_pkg::DATA_W-1:0] test_step,
    input  int   words_left_expected,  // extra words queued beyond one load
    input  int   words_left,
    input  logic sweep_active,
    input  logic load_timeout,
    input  logic test_end,
    output int   tests_run,
    output int   tests_failed,
    output int   error_total
);

    logic armed;         // start seen since the last tile reset
    logic tile_reset_q;
    logic sweep_q;
    logic [weight_bank_pkg::BANK_COUNT-1:0][weight_bank_pkg::BANK_ADDR_W-1:0] addr_q;
    int   pop_cnt;
    int   test_errs;
    int   words_checked;

    initial begin
        tests_run     = 0;
        tests_failed  = 0;
        error_total   = 0;
        pop_cnt       = 0;
        test_errs     = 0;
        words_checked = 0;
    end

    // word n of a load sits in output group n/36, input group (n/9)%4, slot n%9
    function automatic logic [weight_bank_pkg::DATA_W-1:0] expected_word(input int bank,
                                                                         input int addr);
        weight_bank_pkg::weight_bank_sel_t sel;
        int n;
        sel.id = bank[weight_bank_pkg::BANK_SEL_W-1:0];
        n = sel.pair.out_group * weight_geom_pkg::BLOCK_WORDS
            + sel.pair.in_group * weight_geom_pkg::KERNEL_WORDS + addr;
        return weight_bank_pkg::DATA_W'(test_base + n * test_step);
    endfunction

    always @(posedge clk) begin : watch
        logic [weight_bank_pkg::DATA_W-1:0] exp_word;
        if (rst) begin
            armed        <= 1'b0;
            tile_reset_q <= 1'b0;
            sweep_q      <= 1'b0;
            addr_q       <= '0;
        end else begin
            if (weight_load_start) begin
                pop_cnt = 0;
            end
            if (weight_fifo_pop) begin
                pop_cnt++;
                if (weight_fifo_empty) begin
                    $display("weight_fifo_pop was high while the FIFO was empty");
                    test_errs++;
                end
                if (!armed) begin
                    $display("weight_fifo_pop was high before any weight_load_start");
                    test_errs++;
                end
            end
            if (tile_reset_q && weight_load_done) begin
                $display("[ERROR] weight_load_done got 0x%h expected 0x0", weight_load_done);
                test_errs++;
            end
            // read data belongs to the address sampled one edge earlier
            if (sweep_q) begin
                for (int b = 0; b < weight_bank_pkg::BANK_COUNT; b++) begin
                    exp_word = expected_word(b, addr_q[b]);
                    words_checked++;
                    if (rd_data[b] !== exp_word) begin
                        $display("[ERROR] rd_data[%0d] addr 0x%h got 0x%h expected 0x%h",
                                 b, addr_q[b], rd_data[b], exp_word);
                        test_errs++;
                    end
                end
            end
            if (test_end) begin
                if (load_timeout) begin
                    $display("load of %s never raised weight_load_done", test_name);
                    test_errs++;
                end else begin
                    if (weight_load_done !== 1'b1) begin
                        $display("[ERROR] weight_load_done got 0x%h expected 0x1",
                                 weight_load_done);
                        test_errs++;
                    end
                    if (pop_cnt != weight_geom_pkg::LOAD_WORDS) begin
                        $display("[ERROR] weight_fifo_pop count got 0x%h expected 0x%h",
                                 pop_cnt, weight_geom_pkg::LOAD_WORDS);
                        test_errs++;
                    end
                    if (words_left != words_left_expected) begin
                        $display("[ERROR] weight_fifo words left got 0x%h expected 0x%h",
                                 words_left, words_left_expected);
                        test_errs++;
                    end
                end
                tests_run++;
                if (test_errs == 0) begin
                    $display("%s pass, %0d words checked, %0d pops", test_name,
                             words_checked, pop_cnt);
                end else begin
                    $display("%s FAIL, %0d errors", test_name, test_errs);
                    tests_failed++;
                end
                error_total   = error_total + test_errs;
                test_errs     = 0;
                words_checked = 0;
            end
            if (conv_tile_reset) begin
                armed <= 1'b0;
            end else if (weight_load_start) begin
                armed <= 1'b1;
            end
            tile_reset_q <= conv_tile_reset;
            sweep_q      <= sweep_active;
            addr_q       <= rd_addr;
        end
    end

endmodule

`default_nettype wire

// File: source/weight_bank.sv
// one weight bank, written in order from a moving pointer and read through a registered port
`default_nettype none

module weight_bank (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    conv_tile_reset,
    input  logic                                    wr_en,
    input  logic [weight_bank_pkg::DATA_W-1:0]      wr_data,
    input  logic [weight_bank_pkg::BANK_ADDR_W-1:0] rd_addr,
    output logic [weight_bank_pkg::DATA_W-1:0]      rd_data
);

    logic [weight_bank_pkg::DATA_W-1:0]      mem [weight_bank_pkg::BANK_DEPTH];
    logic [weight_bank_pkg::BANK_ADDR_W-1:0] wr_ptr;  // next slot to fill

    // words arrive in kernel order, so the pointer just counts up
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (conv_tile_reset) begin
            wr_ptr <= '0;  // next tile starts at slot 0
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // the selector must not hand this bank more than its share of a load
    no_overfill: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> int'(wr_ptr) < weight_bank_pkg::BANK_DEPTH
    ) else $error("write to full weight bank");

endmodule

`default_nettype wire

// File: source/weight_bank_pkg.sv
// bank sizes, word widths and the bank select word shared by the selector, banks and checker
`default_nettype none

package weight_bank_pkg;

    localparam int DATA_W      = 16;  // weight word
    localparam int BANK_COUNT  = weight_geom_pkg::IN_GROUPS * weight_geom_pkg::OUT_GROUPS;
    localparam int BANK_DEPTH  = weight_geom_pkg::LOAD_WORDS / BANK_COUNT;  // 9 words
    localparam int BANK_ADDR_W = 4;
    localparam int BANK_SEL_W  = $clog2(BANK_COUNT);
    localparam int GROUP_W     = 2;  // one channel group index

    localparam logic [GROUP_W-1:0] IN_GROUP_LAST  = GROUP_W'(weight_geom_pkg::IN_GROUPS - 1);
    localparam logic [GROUP_W-1:0] OUT_GROUP_LAST = GROUP_W'(weight_geom_pkg::OUT_GROUPS - 1);

    // output group in the high bits so the flat id walks input groups first
    typedef struct packed {
        logic [GROUP_W-1:0] out_group;
        logic [GROUP_W-1:0] in_group;
    } weight_bank_pair_t;

    // same four bits seen as a bank number or as a group pair
    typedef union packed {
        logic [BANK_SEL_W-1:0] id;
        weight_bank_pair_t     pair;
    } weight_bank_sel_t;

endpackage

`default_nettype wire

// File: source/weight_bank_sel.sv
// tracks kernel and block position of each popped word and steers it to one weight bank
`default_nettype none

module weight_bank_sel (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     conv_tile_reset,
    input  logic                                     weight_fifo_pop,
    input  logic [weight_bank_pkg::DATA_W-1:0]       weight_fifo_data,
    output logic [weight_bank_pkg::BANK_COUNT-1:0]   bank_wr_en,    // one-hot or zero
    output logic [weight_bank_pkg::DATA_W-1:0]       bank_wr_data
);

    logic [weight_geom_pkg::KERNEL_CNT_W-1:0] kernel_cnt;  // word within the kernel
    logic [weight_geom_pkg::BLOCK_CNT_W-1:0]  block_cnt;   // word within the block
    logic [weight_bank_pkg::GROUP_W-1:0]      in_group;
    logic [weight_bank_pkg::GROUP_W-1:0]      out_group;
    logic                                     kernel_end;
    logic                                     block_end;

    weight_bank_pkg::weight_bank_sel_t cur_sel;

    assign kernel_end = (kernel_cnt == weight_geom_pkg::KERNEL_LAST);
    assign block_end  = (block_cnt == weight_geom_pkg::BLOCK_LAST);

    // kernel and block word counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kernel_cnt <= '0;
            block_cnt  <= '0;
        end else if (conv_tile_reset) begin
            kernel_cnt <= '0;
            block_cnt  <= '0;
        end else if (weight_fifo_pop) begin
            kernel_cnt <= kernel_end ? '0 : kernel_cnt + 1'b1;
            block_cnt  <= block_end ? '0 : block_cnt + 1'b1;
        end
    end

    // input group steps after every kernel, wraps at IN_GROUPS
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_group <= '0;
        end else if (conv_tile_reset) begin
            in_group <= '0;
        end else if (weight_fifo_pop && kernel_end) begin
            if (in_group == weight_bank_pkg::IN_GROUP_LAST) begin
                in_group <= '0;
            end else begin
                in_group <= in_group + 1'b1;
            end
        end
    end

    // output group steps after every block, wraps at OUT_GROUPS
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_group <= '0;
        end else if (conv_tile_reset) begin
            out_group <= '0;
        end else if (weight_fifo_pop && block_end) begin
            if (out_group == weight_bank_pkg::OUT_GROUP_LAST) begin
                out_group <= '0;
            end else begin
                out_group <= out_group + 1'b1;
            end
        end
    end

    // pack the pair, read back the flat bank number
    always_comb begin
        cur_sel.pair.out_group = out_group;
        cur_sel.pair.in_group  = in_group;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_wr_en <= '0;
        end else begin
            bank_wr_en <= '0;
            if (weight_fifo_pop) begin
                bank_wr_en[cur_sel.id] <= 1'b1;
            end
        end
    end

    // data travels with its enable
    always_ff @(posedge clk) begin
        if (weight_fifo_pop) begin
            bank_wr_data <= weight_fifo_data;
        end
    end

    // block position is the whole kernels passed plus the word within the kernel
    counters_in_step: assert property (
        @(posedge clk) disable iff (rst)
        int'(block_cnt) == int'(in_group) * weight_geom_pkg::KERNEL_WORDS + int'(kernel_cnt)
    ) else $error("block_cnt out of step with in_group and kernel_cnt");

endmodule

`default_nettype wire

// File: source/weight_buffer.sv
// weight buffer top level, loads a tile of weights from a FIFO into sixteen readable banks
`default_nettype none

module weight_buffer (
    input  logic clk,
    input  logic rst,

    // load control
    input  logic weight_load_start,
    input  logic conv_tile_reset,
    output logic weight_load_done,

    // FIFO side
    input  logic                                    weight_fifo_empty,
    input  logic [weight_bank_pkg::DATA_W-1:0]      weight_fifo_data,
    output logic                                    weight_fifo_pop,

    // read side, indexed by flat bank number
    input  logic [weight_bank_pkg::BANK_COUNT-1:0][weight_bank_pkg::BANK_ADDR_W-1:0] rd_addr,
    output logic [weight_bank_pkg::BANK_COUNT-1:0][weight_bank_pkg::DATA_W-1:0]      rd_data
);

    logic [weight_bank_pkg::BANK_COUNT-1:0] bank_wr_en;
    logic [weight_bank_pkg::DATA_W-1:0]     bank_wr_data;

    weight_load_ctrl weight_load_ctrl_inst (
        .clk               (clk),
        .rst               (rst),
        .weight_load_start (weight_load_start),
        .conv_tile_reset   (conv_tile_reset),
        .weight_fifo_empty (weight_fifo_empty),
        .weight_fifo_pop   (weight_fifo_pop),
        .weight_load_done  (weight_load_done)
    );

    weight_bank_sel weight_bank_sel_inst (
        .clk              (clk),
        .rst              (rst),
        .conv_tile_reset  (conv_tile_reset),
        .weight_fifo_pop  (weight_fifo_pop),
        .weight_fifo_data (weight_fifo_data),
        .bank_wr_en       (bank_wr_en),
        .bank_wr_data     (bank_wr_data)
    );

    // bank b holds output group b/4, input group b%4
    for (genvar b = 0; b < weight_bank_pkg::BANK_COUNT; b++) begin : g_bank
        weight_bank weight_bank_inst (
            .clk             (clk),
            .rst             (rst),
            .conv_tile_reset (conv_tile_reset),
            .wr_en           (bank_wr_en[b]),
            .wr_data         (bank_wr_data),  // shared, enable picks the bank
            .rd_addr         (rd_addr[b]),
            .rd_data         (rd_data[b])
        );
    end

endmodule

`default_nettype wire

// File: source/weight_geom_pkg.sv
// tile geometry of the weight buffer and the load sizes derived from it, shared by the RTL
`default_nettype none

package weight_geom_pkg;

    localparam int KERNEL_DIM = 3;  // kernel side K
    localparam int TILE_IN    = 4;  // Tm, input channels per tile
    localparam int TILE_OUT   = 4;  // Tn, output channels per tile

    // bank grid, one bank per (output group, input group)
    localparam int IN_GROUPS  = 4;  // X
    localparam int OUT_GROUPS = 4;  // Y

    // words before the input group advances
    localparam int KERNEL_WORDS = KERNEL_DIM * KERNEL_DIM;
    // words before the output group advances
    localparam int BLOCK_WORDS  = KERNEL_WORDS * TILE_IN;
    // one complete load, Tm*Tn*K*K
    localparam int LOAD_WORDS   = BLOCK_WORDS * TILE_OUT;

    localparam int LOAD_CNT_W   = 8;
    localparam int KERNEL_CNT_W = $clog2(KERNEL_WORDS);
    localparam int BLOCK_CNT_W  = $clog2(BLOCK_WORDS);

    // last value of each position counter, sized to the counter
    localparam logic [KERNEL_CNT_W-1:0] KERNEL_LAST = KERNEL_CNT_W'(KERNEL_WORDS - 1);
    localparam logic [BLOCK_CNT_W-1:0]  BLOCK_LAST  = BLOCK_CNT_W'(BLOCK_WORDS - 1);
    localparam logic [LOAD_CNT_W-1:0]   LOAD_LAST   = LOAD_CNT_W'(LOAD_WORDS - 1);

endpackage

`default_nettype wire

// File: source/weight_load_ctrl.sv
// load session control, drives the weight FIFO pop and flags when a full tile is loaded
`default_nettype none

module weight_load_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic weight_load_start,   // one-cycle pulse
    input  logic conv_tile_reset,     // rewinds for the next tile
    input  logic weight_fifo_empty,
    output logic weight_fifo_pop,
    output logic weight_load_done
);

    logic                                  load_active;
    logic [weight_geom_pkg::LOAD_CNT_W-1:0] load_cnt;  // pops so far

    // active from the edge after start until done
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_active <= 1'b0;
        end else if (weight_load_start) begin
            load_active <= 1'b1;
        end else if (weight_load_done) begin
            load_active <= 1'b0;
        end
    end

    // first-word-fall-through, an empty FIFO just stalls the load
    assign weight_fifo_pop = load_active && !weight_fifo_empty && !weight_load_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_cnt         <= '0;
            weight_load_done <= 1'b0;
        end else if (conv_tile_reset) begin
            load_cnt         <= '0;
            weight_load_done <= 1'b0;
        end else if (weight_fifo_pop) begin
            load_cnt <= load_cnt + 1'b1;
            if (load_cnt == weight_geom_pkg::LOAD_LAST) begin
                weight_load_done <= 1'b1;  // rises on the edge of the last pop
            end
        end
    end

    // done marks exactly a fully counted load
    done_at_full_count: assert property (
        @(posedge clk) disable iff (rst)
        weight_load_done == (load_cnt == weight_geom_pkg::LOAD_WORDS)
    ) else $error("weight_load_done out of step with load_cnt");

    // done holds until the tile is rewound
    done_sticky: assert property (
        @(posedge clk) disable iff (rst)
        weight_load_done && !conv_tile_reset |=> weight_load_done
    ) else $error("weight_load_done dropped before conv_tile_reset");

endmodule

`default_nettype wire

// File: src.f
source/weight_geom_pkg.sv
source/weight_bank_pkg.sv
source/weight_load_ctrl.sv
source/weight_bank_sel.sv
source/weight_bank.sv
source/weight_buffer.sv
bench/weight_buffer_checker.sv
bench/tb_weight_buffer.sv
